// ==== design/fxpPkg.sv ====
package fxpPkg;

    // Signed fixed-point format, sign + integer + fraction
    localparam int intBits  = 8;
    localparam int fracBits = 8;
    localparam int fxpWidth = intBits + fracBits + 1;

    // Factors, table entries, partial sums and results all share this format
    typedef logic signed [fxpWidth-1:0] fxp_t;

endpackage

// ==== design/daPkg.sv ====
package daPkg;

    localparam int stepIdxWidth = 8;

    // Evaluation sequence
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        RUN,
        FLUSH,
        FINISH
    } daState_e;

    // Control word from the sequencer to the datapath
    typedef struct packed {
        logic                    capture;
        logic                    stepValid;
        logic                    firstStep;
        logic                    lastStep;
        logic [stepIdxWidth-1:0] stepIndex;
    } stepCtrl_t;

endpackage

// ==== design/daLut.sv ====
`timescale 1ns/1ps

module daLut #(
    parameter int                         lutSize = 4,
    parameter fxpPkg::fxp_t [lutSize-1:0] factors = '0
) (
    input  logic [lutSize-1:0] grp,
    output fxpPkg::fxp_t       value
);
    import fxpPkg::*;

    localparam int numEntries = 1 << lutSize;

    // Entry e holds the sum of +factor where bit j of e is set, -factor otherwise
    function automatic fxp_t [numEntries-1:0] buildTable();
        fxp_t [numEntries-1:0] tbl;
        fxp_t                  acc;
        for (int e = 0; e < numEntries; e++) begin
            acc = '0;
            for (int j = 0; j < lutSize; j++) begin
                if (((e >> j) & 1) == 1) begin
                    acc = acc + factors[j];
                end else begin
                    acc = acc - factors[j];
                end
            end
            tbl[e] = acc;
        end
        return tbl;
    endfunction

    localparam fxp_t [numEntries-1:0] lutTable = buildTable();

    assign value = lutTable[grp];

endmodule

// ==== design/daLutBank.sv ====
`timescale 1ns/1ps

module daLutBank #(
    parameter int                        numSel  = 16,
    parameter int                        lutSize = 4,
    parameter fxpPkg::fxp_t [numSel-1:0] factors = '0,
    localparam int                       numLuts = (numSel + lutSize - 1) / lutSize
) (
    input  logic             clk,
    input  logic             rstPulse,
    input  daPkg::stepCtrl_t stepCtrl,
    input  logic [numSel-1:0] sel,
    output fxpPkg::fxp_t     lutOut [numLuts]
);
    import fxpPkg::*;

    logic [numSel-1:0] selReg;

    // Selector is held for the whole run so sel may move freely
    always_ff @(posedge clk or posedge rstPulse) begin
        if (rstPulse) begin
            selReg <= '0;
        end else if (stepCtrl.capture) begin
            selReg <= sel;
        end
    end

    for (genvar g = 0; g < numLuts; g++) begin : gLut
        localparam int offset  = g * lutSize;
        // Last group may be short
        localparam int grpSize = (numSel - offset < lutSize) ? (numSel - offset) : lutSize;

        fxp_t grpValue;

        daLut #(
            .lutSize (grpSize),
            .factors (factors[offset +: grpSize])
        ) u_lut (
            .grp   (selReg[offset +: grpSize]),
            .value (grpValue)
        );

        always_ff @(posedge clk or posedge rstPulse) begin
            if (rstPulse) begin
                lutOut[g] <= '0;
            end else begin
                lutOut[g] <= grpValue;
            end
        end
    end

endmodule

// ==== design/daAdderTree.sv ====
`timescale 1ns/1ps

module daAdderTree #(
    parameter int  numSel      = 16,
    parameter int  lutSize     = 4,
    parameter int  lutsPerStep = 2,
    localparam int numLuts     = (numSel + lutSize - 1) / lutSize
) (
    input  logic             clk,
    input  logic             rstPulse,
    input  daPkg::stepCtrl_t stepCtrl,
    input  fxpPkg::fxp_t     lutOut [numLuts],
    output fxpPkg::fxp_t     stepSum,
    output logic             sumValid,
    output logic             sumFirst,
    output logic             sumLast
);
    import fxpPkg::*;

    // Leaves padded up to a power of two
    localparam int treeDepth = $clog2(lutsPerStep);
    localparam int treeWidth = 1 << treeDepth;

    int   stepBase;
    fxp_t leaves [treeWidth];

    // Pairwise reduction, one level per pass, wraps modulo 2^fxpWidth
    function automatic fxp_t sumTree(fxp_t leafIn [treeWidth]);
        fxp_t node [treeWidth];
        node = leafIn;
        for (int lvl = 0; lvl < treeDepth; lvl++) begin
            for (int i = 0; i < (treeWidth >> (lvl + 1)); i++) begin
                node[i] = node[2*i] + node[2*i+1];
            end
        end
        return node[0];
    endfunction

    always_comb begin
        stepBase = int'(stepCtrl.stepIndex) * lutsPerStep;
        for (int i = 0; i < treeWidth; i++) begin
            if (i < lutsPerStep && stepBase + i < numLuts) begin
                leaves[i] = lutOut[stepBase + i];
            end else begin
                leaves[i] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stepCtrl.stepValid) begin
            stepSum <= sumTree(leaves);
        end
    end

    // Step marks follow the sum by one cycle
    always_ff @(posedge clk or posedge rstPulse) begin
        if (rstPulse) begin
            sumValid <= 1'b0;
            sumFirst <= 1'b0;
            sumLast  <= 1'b0;
        end else begin
            sumValid <= stepCtrl.stepValid;
            sumFirst <= stepCtrl.stepValid && stepCtrl.firstStep;
            sumLast  <= stepCtrl.stepValid && stepCtrl.lastStep;
        end
    end

endmodule

// ==== design/daAccumulator.sv ====
`timescale 1ns/1ps

module daAccumulator (
    input  logic         clk,
    input  logic         rstPulse,
    input  fxpPkg::fxp_t stepSum,
    input  logic         sumValid,
    input  logic         sumFirst,
    input  logic         sumLast,
    output fxpPkg::fxp_t result,
    output logic         accDone
);
    import fxpPkg::*;

    fxp_t runSum;
    fxp_t nextSum;

    // First step restarts the sum
    assign nextSum = sumFirst ? stepSum : runSum + stepSum;

    always_ff @(posedge clk) begin
        if (sumValid) begin
            runSum <= nextSum;
        end
    end

    // Result only ever shows a finished sum
    always_ff @(posedge clk or posedge rstPulse) begin
        if (rstPulse) begin
            result  <= '0;
            accDone <= 1'b0;
        end else begin
            accDone <= sumValid && sumLast;
            if (sumValid && sumLast) begin
                result <= nextSum;
            end
        end
    end

endmodule

// ==== design/daControl.sv ====
`timescale 1ns/1ps

module daControl #(
    parameter int numSel      = 16,
    parameter int lutSize     = 4,
    parameter int lutsPerStep = 2
) (
    input  logic             clk,
    input  logic             rstPulse,
    input  logic             start,
    input  logic             accDone,
    output daPkg::stepCtrl_t stepCtrl,
    output logic             busy,
    output logic             done
);
    import daPkg::*;

    localparam int numLuts  = (numSel + lutSize - 1) / lutSize;
    localparam int numSteps = (numLuts + lutsPerStep - 1) / lutsPerStep;

    daState_e                state;
    logic [stepIdxWidth-1:0] stepCnt;

    always_ff @(posedge clk or posedge rstPulse) begin
        if (rstPulse) begin
            state   <= IDLE;
            stepCnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state   <= LOAD;
                        stepCnt <= '0;
                    end
                end
                LOAD: begin
                    state <= RUN;
                end
                RUN: begin
                    if (stepCnt == stepIdxWidth'(numSteps - 1)) begin
                        state   <= FLUSH;
                        stepCnt <= '0;
                    end else begin
                        stepCnt <= stepCnt + 1'b1;
                    end
                end
                FLUSH: begin
                    // Last partial sum moves from the tree into the accumulator
                    state <= FINISH;
                end
                FINISH: begin
                    // accDone arrives in this cycle
                    if (accDone) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Starts outside IDLE are dropped here
    assign stepCtrl.capture   = (state == IDLE) && start;
    assign stepCtrl.stepValid = (state == RUN);
    assign stepCtrl.firstStep = (state == RUN) && (stepCnt == '0);
    assign stepCtrl.lastStep  = (state == RUN) && (stepCnt == stepIdxWidth'(numSteps - 1));
    assign stepCtrl.stepIndex = stepCnt;

    assign busy = (state != IDLE);
    assign done = accDone;

endmodule

// ==== design/daEngine.sv ====
`timescale 1ns/1ps

module daEngine #(
    parameter int                        numSel      = 16,
    parameter int                        lutSize     = 4,
    parameter int                        lutsPerStep = 2,
    parameter fxpPkg::fxp_t [numSel-1:0] factors     = '0
) (
    input  logic              clk,
    input  logic              rstPulse,
    input  logic              start,
    input  logic [numSel-1:0] sel,
    output fxpPkg::fxp_t      result,
    output logic              done,
    output logic              busy
);
    import fxpPkg::*;
    import daPkg::*;

    localparam int numLuts = (numSel + lutSize - 1) / lutSize;

    stepCtrl_t stepCtrl;
    fxp_t      lutOut [numLuts];
    fxp_t      stepSum;
    logic      sumValid;
    logic      sumFirst;
    logic      sumLast;
    logic      accDone;

    daControl #(
        .numSel      (numSel),
        .lutSize     (lutSize),
        .lutsPerStep (lutsPerStep)
    ) u_control (
        .clk      (clk),
        .rstPulse (rstPulse),
        .start    (start),
        .accDone  (accDone),
        .stepCtrl (stepCtrl),
        .busy     (busy),
        .done     (done)
    );

    daLutBank #(
        .numSel  (numSel),
        .lutSize (lutSize),
        .factors (factors)
    ) u_lutBank (
        .clk      (clk),
        .rstPulse (rstPulse),
        .stepCtrl (stepCtrl),
        .sel      (sel),
        .lutOut   (lutOut)
    );

    daAdderTree #(
        .numSel      (numSel),
        .lutSize     (lutSize),
        .lutsPerStep (lutsPerStep)
    ) u_adderTree (
        .clk      (clk),
        .rstPulse (rstPulse),
        .stepCtrl (stepCtrl),
        .lutOut   (lutOut),
        .stepSum  (stepSum),
        .sumValid (sumValid),
        .sumFirst (sumFirst),
        .sumLast  (sumLast)
    );

    daAccumulator u_accumulator (
        .clk      (clk),
        .rstPulse (rstPulse),
        .stepSum  (stepSum),
        .sumValid (sumValid),
        .sumFirst (sumFirst),
        .sumLast  (sumLast),
        .result   (result),
        .accDone  (accDone)
    );

endmodule

// ==== sim/daEngine_checker.sv ====
`timescale 1ns/1ps

module daEngine_checker (
    input logic         clk,
    input logic         rstPulse,
    input logic         done,
    input logic         busy,
    input fxpPkg::fxp_t result
);

    int violations = 0;

    donePulse: assert property (@(posedge clk) disable iff (rstPulse) done |=> !done)
    else begin
        violations++;
        $error("done stayed high for more than one cycle");
    end

    doneBusy: assert property (@(posedge clk) disable iff (rstPulse) done |-> busy)
    else begin
        violations++;
        $error("done pulsed while busy was low");
    end

    // Async reset, so outputs are already quiet at the first edge
    resetQuiet: assert property (@(posedge clk) rstPulse |-> !done && !busy)
    else begin
        violations++;
        $error("done or busy high during reset");
    end

    resultHeld: assert property (@(posedge clk) disable iff (rstPulse) !done |-> $stable(result))
    else begin
        violations++;
        $error("result changed without a done pulse");
    end

endmodule

bind daEngine daEngine_checker u_checker (
    .clk      (clk),
    .rstPulse (rstPulse),
    .done     (done),
    .busy     (busy),
    .result   (result)
);

// ==== sim/daEngine_tb.sv ====
`timescale 1ns/1ps

module daEngine_tb;
    import fxpPkg::*;

    localparam int numSel      = 16;
    localparam int lutSize     = 4;
    localparam int lutsPerStep = 2;
    localparam int numLuts     = (numSel + lutSize - 1) / lutSize;
    localparam int numSteps    = (numLuts + lutsPerStep - 1) / lutsPerStep;
    localparam int resetCycles = 5;
    localparam int numRandom   = 200;
    localparam int holdCycles  = 8;
    // Corners, random runs, the busy run and the run after the hold
    localparam int numEvals    = 2 + numSel + numRandom + 2;
    localparam int timeoutCycles =
        numEvals * (numSteps + 3 + 2) + resetCycles + holdCycles + 50;

    // 8.8 values with mixed signs and fractions, total magnitude about 72
    localparam fxp_t [numSel-1:0] tbFactors = {
        fxp_t'(2048), fxp_t'(-288), fxp_t'(512), fxp_t'(-896),
        fxp_t'(1600), fxp_t'(16), fxp_t'(-2304), fxp_t'(3200),
        fxp_t'(1024), fxp_t'(-96), fxp_t'(2560), fxp_t'(-1984),
        fxp_t'(128), fxp_t'(800), fxp_t'(-576), fxp_t'(384)
    };

    logic              clk;
    logic              rstPulse;
    logic              start;
    logic [numSel-1:0] sel;
    fxp_t              result;
    logic              done;
    logic              busy;

    integer seed       = 32'hdf8eacc2;
    int     cycleCount = 0;
    bit     pending    = 1'b0;
    fxp_t   expected;
    string  testName;

    daEngine #(
        .numSel      (numSel),
        .lutSize     (lutSize),
        .lutsPerStep (lutsPerStep),
        .factors     (tbFactors)
    ) u_daEngine (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Set bit adds its factor, clear bit subtracts it, wraps at 17 bits
    function automatic fxp_t refSum(input logic [numSel-1:0] s);
        fxp_t acc;
        acc = '0;
        for (int i = 0; i < numSel; i++) begin
            acc = s[i] ? acc + tbFactors[i] : acc - tbFactors[i];
        end
        return acc;
    endfunction

    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic checkEqual(input string name, input logic signed [31:0] expVal,
                              input logic signed [31:0] actVal);
        if (actVal !== expVal) begin
            stopWithFailure($sformatf("FAILED %s: expected %0d, actual %0d",
                                      name, expVal, actVal));
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            stopWithFailure("Timeout: the run went past its cycle budget");
        end
    end

    // Sampled mid-cycle, away from the active edge
    always @(negedge clk) begin
        if (u_daEngine.u_checker.violations != 0) begin
            stopWithFailure("A bound assertion on the DUT failed");
        end
        if (!rstPulse && done) begin
            if (!pending) begin
                stopWithFailure("done pulsed with no evaluation pending");
            end
            checkEqual(testName, expected, result);
            pending = 1'b0;
        end
    end

    // pokeStart raises start once more while the run is busy
    task automatic runEval(input string name, input logic [numSel-1:0] selValue,
                           input bit pokeStart);
        int latency;
        @(posedge clk);
        start    <= 1'b1;
        sel      <= selValue;
        testName = name;
        expected = refSum(selValue);
        pending  = 1'b1;
        @(posedge clk);
        start <= 1'b0;
        sel   <= numSel'($random(seed));
        // Edge at which done gets sampled, counted from the start edge
        latency = 1;
        @(negedge clk);
        while (!done) begin
            checkEqual({name, " busy"}, 1, busy);
            if (latency > 4 * (numSteps + 3)) begin
                stopWithFailure({"No done pulse arrived for ", name});
            end
            @(posedge clk);
            start <= pokeStart && latency == 2;
            sel   <= numSel'($random(seed));
            latency++;
            @(negedge clk);
        end
        checkEqual({name, " busy at done"}, 1, busy);
        checkEqual({name, " latency"}, numSteps + 3, latency);
    endtask

    initial begin
        fxp_t heldValue;
        rstPulse = 1'b1;
        start    = 1'b0;
        sel      = '0;
        repeat (resetCycles) @(posedge clk);
        rstPulse <= 1'b0;
        @(negedge clk);
        checkEqual("reset done", 0, done);
        checkEqual("reset busy", 0, busy);
        checkEqual("reset result", 0, result);

        runEval("all ones", '1, 1'b0);
        runEval("all zeros", '0, 1'b0);
        for (int k = 0; k < numSel; k++) begin
            runEval($sformatf("single bit %0d", k), numSel'(1) << k, 1'b0);
        end
        for (int n = 0; n < numRandom; n++) begin
            runEval($sformatf("random %0d", n), numSel'($random(seed)), 1'b0);
        end

        // Second start must be dropped, then result holds while idle
        runEval("start while busy", numSel'($random(seed)), 1'b1);
        heldValue = result;
        repeat (holdCycles) begin
            @(negedge clk);
            checkEqual("busy after done", 0, busy);
            checkEqual("result held while idle", heldValue, result);
        end
        runEval("after idle hold", numSel'($random(seed)), 1'b0);

        @(negedge clk);
        if (u_daEngine.u_checker.violations != 0) begin
            stopWithFailure("A bound assertion on the DUT failed");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
design/fxpPkg.sv
design/daPkg.sv
design/daLut.sv
design/daLutBank.sv
design/daAdderTree.sv
design/daAccumulator.sv
design/daControl.sv
design/daEngine.sv
sim/daEngine_checker.sv
sim/daEngine_tb.sv

// ==== Bender.yml ====
package:
  name: daEngine

sources:
  - design/fxpPkg.sv
  - design/daPkg.sv
  - design/daLut.sv
  - design/daLutBank.sv
  - design/daAdderTree.sv
  - design/daAccumulator.sv
  - design/daControl.sv
  - design/daEngine.sv
  - target: simulation
    files:
      - sim/daEngine_checker.sv
      - sim/daEngine_tb.sv
